/* Makefile */
# Verilator build and run of the cpu core testbench

VERILATOR  ?= verilator
TOP        ?= tb_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
SIM_BIN    ?= sim_tb
VFLAGS     ?= --binary --timing --timescale 1ns/1ns
LINT_FLAGS ?= --lint-only --timing --timescale 1ns/1ns -Wall
PASS_TEXT  ?= Test passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)

run: build
	@out="$$(./$(BUILD_DIR)/$(SIM_BIN) 2>&1)"; echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

/* design/cpu_config.svh */
// ##################################################
// core configuration macros
// data width, register file size and reset vector
// ##################################################

`ifndef CPU_CONFIG_SVH
`define CPU_CONFIG_SVH

// data and address width
`define CPU_XLEN        32

// general purpose registers
`define CPU_REG_COUNT   32
`define CPU_REG_ADDR_W  5

// first fetch after reset
`define CPU_RESET_PC    32'hbfc00000

`endif

/* design/cpu_pkg.sv */
// ##################################################
// core types: alu ops, opcodes, branch kinds
// and the three pipeline stage payloads
// ##################################################
`default_nettype none
`include "cpu_config.svh"

package cpu_pkg;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SLT, ALU_LUI
    } alu_op_t;

    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,                         // r-type, funct decides
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_ORI     = 6'h0d,
        OP_LUI     = 6'h0f
    } opcode_t;

    typedef enum logic [1:0] {BR_NONE, BR_EQ, BR_NE} branch_kind_t;

    typedef struct packed {
        logic                       valid;
        logic [`CPU_XLEN-1:0]       pc;
        logic [`CPU_XLEN-1:0]       instr;
    } if_id_t;

    typedef struct packed {
        logic                       valid;
        logic [`CPU_XLEN-1:0]       pc;
        logic [`CPU_XLEN-1:0]       op_a;
        logic [`CPU_XLEN-1:0]       op_b;       // rt value or extended imm
        logic [`CPU_REG_ADDR_W-1:0] src_a;
        logic [`CPU_REG_ADDR_W-1:0] src_b;
        logic                       b_is_imm;
        alu_op_t                    alu_op;
        logic [`CPU_REG_ADDR_W-1:0] dst;
        logic                       we;
        branch_kind_t               branch;
        logic [`CPU_XLEN-1:0]       br_target;
    } id_ex_t;

    typedef struct packed {
        logic                       valid;
        logic [`CPU_XLEN-1:0]       pc;
        logic [`CPU_XLEN-1:0]       result;
        logic [`CPU_REG_ADDR_W-1:0] dst;
        logic                       we;
    } ex_wb_t;

endpackage

`default_nettype wire

/* design/decode_stage.sv */
// ##################################################
// decode stage
// instruction decoder, branch target, register file
// ##################################################
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module decode_stage
    import cpu_pkg::*;
(
    input  wire logic                       aclk,
    input  wire if_id_t                     if_id_q,
    input  wire logic                       wb_we,
    input  wire logic [`CPU_REG_ADDR_W-1:0] wb_dst,
    input  wire logic [`CPU_XLEN-1:0]       wb_data,
    output id_ex_t                          id_ex_d
);

    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_XOR  = 6'h26;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [1:0] {IMM_SIGN, IMM_ZERO, IMM_UPPER} imm_kind_t;

    logic [`CPU_XLEN-1:0]       regs [`CPU_REG_COUNT];
    logic [5:0]                 opcode;
    logic [5:0]                 funct;
    logic [`CPU_REG_ADDR_W-1:0] rs;
    logic [`CPU_REG_ADDR_W-1:0] rt;
    logic [`CPU_REG_ADDR_W-1:0] rd;
    logic [15:0]                imm;
    logic [`CPU_XLEN-1:0]       imm_sext;
    logic [`CPU_XLEN-1:0]       imm_ext;
    logic [`CPU_XLEN-1:0]       rs_val;
    logic [`CPU_XLEN-1:0]       rt_val;
    imm_kind_t                  imm_kind;
    alu_op_t                    alu_op;
    branch_kind_t               br_kind;
    logic                       b_is_imm;
    logic                       we;
    logic [`CPU_REG_ADDR_W-1:0] dst;

    assign opcode   = if_id_q.instr[31:26];
    assign rs       = if_id_q.instr[25:21];
    assign rt       = if_id_q.instr[20:16];
    assign rd       = if_id_q.instr[15:11];
    assign funct    = if_id_q.instr[5:0];
    assign imm      = if_id_q.instr[15:0];
    assign imm_sext = {{16{imm[15]}}, imm};

    always_comb begin
        alu_op   = ALU_ADD;
        imm_kind = IMM_SIGN;
        b_is_imm = 1'b0;
        dst      = rt;
        we       = 1'b0;
        br_kind  = BR_NONE;
        case (opcode)
            OP_SPECIAL: begin
                dst = rd;
                we  = 1'b1;
                case (funct)
                    FN_ADDU: alu_op = ALU_ADD;
                    FN_SUBU: alu_op = ALU_SUB;
                    FN_AND:  alu_op = ALU_AND;
                    FN_OR:   alu_op = ALU_OR;
                    FN_XOR:  alu_op = ALU_XOR;
                    FN_SLT:  alu_op = ALU_SLT;
                    default: we = 1'b0;         // unknown funct runs as nop
                endcase
            end
            OP_ADDIU: begin
                b_is_imm = 1'b1;
                we       = 1'b1;
            end
            OP_ORI: begin
                alu_op   = ALU_OR;
                imm_kind = IMM_ZERO;
                b_is_imm = 1'b1;
                we       = 1'b1;
            end
            OP_LUI: begin
                alu_op   = ALU_LUI;
                imm_kind = IMM_UPPER;
                b_is_imm = 1'b1;
                we       = 1'b1;
            end
            OP_BEQ:  br_kind = BR_EQ;
            OP_BNE:  br_kind = BR_NE;
            default: ;                          // nop, no writeback
        endcase
    end

    always_comb begin
        case (imm_kind)
            IMM_ZERO:  imm_ext = {16'h0000, imm};
            IMM_UPPER: imm_ext = {imm, 16'h0000};
            default:   imm_ext = imm_sext;
        endcase
    end

    // register file, r0 stays zero
    always_ff @(posedge aclk) begin
        if (wb_we && wb_dst != '0) begin
            regs[wb_dst] <= wb_data;
        end
    end

    // same-cycle write passes through to the read
    assign rs_val = (rs == '0) ? '0 : (wb_we && wb_dst == rs) ? wb_data : regs[rs];
    assign rt_val = (rt == '0) ? '0 : (wb_we && wb_dst == rt) ? wb_data : regs[rt];

    assign id_ex_d.valid     = if_id_q.valid;
    assign id_ex_d.pc        = if_id_q.pc;
    assign id_ex_d.op_a      = rs_val;
    assign id_ex_d.op_b      = b_is_imm ? imm_ext : rt_val;
    assign id_ex_d.src_a     = rs;
    assign id_ex_d.src_b     = rt;
    assign id_ex_d.b_is_imm  = b_is_imm;
    assign id_ex_d.alu_op    = alu_op;
    assign id_ex_d.dst       = dst;
    assign id_ex_d.we        = we;
    assign id_ex_d.branch    = br_kind;
    assign id_ex_d.br_target = if_id_q.pc + 32'd4 + {imm_sext[`CPU_XLEN-3:0], 2'b00};

endmodule

`default_nettype wire

/* design/execute_stage.sv */
// ##################################################
// execute stage
// wb forwarding, alu, branch resolution
// ##################################################
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module execute_stage
    import cpu_pkg::*;
(
    input  wire id_ex_t               id_ex_q,
    input  wire ex_wb_t               ex_wb_q,
    output ex_wb_t                    ex_wb_d,
    output logic                      branch_taken,
    output logic      [`CPU_XLEN-1:0] branch_target
);

    logic                 wb_fwd_ok;
    logic                 fwd_a;
    logic                 fwd_b;
    logic [`CPU_XLEN-1:0] a;
    logic [`CPU_XLEN-1:0] b;
    logic [`CPU_XLEN-1:0] result;
    logic                 slt_bit;
    logic                 equal;

    // older instruction in wb still writing a real register
    assign wb_fwd_ok = ex_wb_q.valid && ex_wb_q.we && (ex_wb_q.dst != '0);

    assign fwd_a = wb_fwd_ok && (ex_wb_q.dst == id_ex_q.src_a);
    assign fwd_b = wb_fwd_ok && !id_ex_q.b_is_imm && (ex_wb_q.dst == id_ex_q.src_b);

    assign a = fwd_a ? ex_wb_q.result : id_ex_q.op_a;
    assign b = fwd_b ? ex_wb_q.result : id_ex_q.op_b;

    assign slt_bit = $signed(a) < $signed(b);

    always_comb begin
        case (id_ex_q.alu_op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            ALU_SLT: result = {{(`CPU_XLEN-1){1'b0}}, slt_bit};
            ALU_LUI: result = b;                    // imm already in upper half
            default: result = '0;
        endcase
    end

    // beq / bne compare on forwarded operands
    assign equal = (a == b);

    always_comb begin
        case (id_ex_q.branch)
            BR_EQ:   branch_taken = id_ex_q.valid && equal;
            BR_NE:   branch_taken = id_ex_q.valid && !equal;
            default: branch_taken = 1'b0;
        endcase
    end

    assign branch_target = id_ex_q.br_target;

    assign ex_wb_d.valid  = id_ex_q.valid;
    assign ex_wb_d.pc     = id_ex_q.pc;
    assign ex_wb_d.result = result;
    assign ex_wb_d.dst    = id_ex_q.dst;
    assign ex_wb_d.we     = id_ex_q.we;

endmodule

`default_nettype wire

/* design/fetch_stage.sv */
// ##################################################
// fetch stage
// pc register, next pc select, if/id payload
// ##################################################
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module fetch_stage
    import cpu_pkg::*;
(
    input  wire logic                 aclk,
    input  wire logic                 reset,
    input  wire logic                 instr_ready,
    input  wire logic                 branch_taken,
    input  wire logic [`CPU_XLEN-1:0] branch_target,
    input  wire logic [`CPU_XLEN-1:0] instr,
    output logic      [`CPU_XLEN-1:0] fetch_pc,
    output if_id_t                    if_id_d
);

    logic [`CPU_XLEN-1:0] next_pc;

    always_comb begin
        if (branch_taken) begin
            next_pc = branch_target;                // redirect wins over busy
        end else if (instr_ready) begin
            next_pc = fetch_pc + 32'd4;
        end else begin
            next_pc = fetch_pc;                     // imem busy, hold
        end
    end

    always_ff @(posedge aclk) begin
        if (reset) begin
            fetch_pc <= `CPU_RESET_PC;
        end else begin
            fetch_pc <= next_pc;
        end
    end

    assign if_id_d.valid = instr_ready;             // busy cycle inserts bubble
    assign if_id_d.pc    = fetch_pc;
    assign if_id_d.instr = instr;

endmodule

`default_nettype wire

/* design/mycpu_top.sv */
// ##################################################
// four-stage cpu core top level
// stages, stage registers, writeback and debug trace
// ##################################################
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module mycpu_top
    import cpu_pkg::*;
(
    input  wire logic                       aclk,
    input  wire logic                       reset,
    input  wire logic                       instr_ready,
    input  wire logic [`CPU_XLEN-1:0]       instr,
    output logic      [`CPU_XLEN-1:0]       fetch_pc,
    output logic      [`CPU_XLEN-1:0]       debug_wb_pc,
    output logic      [`CPU_XLEN-1:0]       debug_wb_rf_wdata,
    output logic      [3:0]                 debug_wb_rf_wen,
    output logic      [`CPU_REG_ADDR_W-1:0] debug_wb_rf_wnum
);

    if_id_t               if_id_d;
    if_id_t               if_id_q;
    id_ex_t               id_ex_d;
    id_ex_t               id_ex_q;
    ex_wb_t               ex_wb_d;
    ex_wb_t               ex_wb_q;
    logic                 branch_taken;
    logic [`CPU_XLEN-1:0] branch_target;
    logic                 wb_we;

    fetch_stage u_fetch (
        .aclk          (aclk),
        .reset         (reset),
        .instr_ready   (instr_ready),
        .branch_taken  (branch_taken),
        .branch_target (branch_target),
        .instr         (instr),
        .fetch_pc      (fetch_pc),
        .if_id_d       (if_id_d)
    );

    pipe_reg #(.payload_t(if_id_t)) u_if_id (
        .aclk  (aclk),
        .reset (reset),
        .flush (branch_taken),                      // kill wrong-path fetch
        .d     (if_id_d),
        .q     (if_id_q)
    );

    decode_stage u_decode (
        .aclk    (aclk),
        .if_id_q (if_id_q),
        .wb_we   (wb_we),
        .wb_dst  (ex_wb_q.dst),
        .wb_data (ex_wb_q.result),
        .id_ex_d (id_ex_d)
    );

    pipe_reg #(.payload_t(id_ex_t)) u_id_ex (
        .aclk  (aclk),
        .reset (reset),
        .flush (branch_taken),                      // kill wrong-path decode
        .d     (id_ex_d),
        .q     (id_ex_q)
    );

    execute_stage u_execute (
        .id_ex_q       (id_ex_q),
        .ex_wb_q       (ex_wb_q),
        .ex_wb_d       (ex_wb_d),
        .branch_taken  (branch_taken),
        .branch_target (branch_target)
    );

    pipe_reg #(.payload_t(ex_wb_t)) u_ex_wb (
        .aclk  (aclk),
        .reset (reset),
        .flush (1'b0),
        .d     (ex_wb_d),
        .q     (ex_wb_q)
    );

    // writeback, r0 writes dropped here
    assign wb_we = ex_wb_q.valid && ex_wb_q.we && (ex_wb_q.dst != '0);

    assign debug_wb_pc       = ex_wb_q.pc;
    assign debug_wb_rf_wdata = ex_wb_q.result;
    assign debug_wb_rf_wen   = {4{wb_we}};          // byte enables, all or none
    assign debug_wb_rf_wnum  = ex_wb_q.dst;

endmodule

`default_nettype wire

/* design/pipe_reg.sv */
// ##################################################
// pipeline stage register
// clears to zero on reset or flush
// ##################################################
`timescale 1ns/1ns
`default_nettype none

module pipe_reg
    import cpu_pkg::*;
#(
    parameter type payload_t = if_id_t
) (
    input  wire logic     aclk,
    input  wire logic     reset,
    input  wire logic     flush,
    input  wire payload_t d,
    output payload_t      q
);

    always_ff @(posedge aclk) begin
        if (reset || flush) begin
            q <= '0;                                // drops valid, becomes bubble
        end else begin
            q <= d;
        end
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+design
design/cpu_pkg.sv
design/pipe_reg.sv
design/fetch_stage.sv
design/decode_stage.sv
design/execute_stage.sv
design/mycpu_top.sv
tests/tb_clock_gen.sv
tests/tb_top.sv

/* tests/cpu_stim.txt */
# p <address> <instruction>          program word, hex
# t <pc> <register> <value>          expected write-back in order, hex
p bfc00000 24010005    # addiu r1, r0, 5
p bfc00004 24220003    # addiu r2, r1, 3
p bfc00008 00221821    # addu  r3, r1, r2
p bfc0000c 00612023    # subu  r4, r3, r1
p bfc00010 3c058000    # lui   r5, 0x8000
p bfc00014 34a51234    # ori   r5, r5, 0x1234
p bfc00018 00a1302a    # slt   r6, r5, r1
p bfc0001c 0025382a    # slt   r7, r1, r5
p bfc00020 00a34024    # and   r8, r5, r3
p bfc00024 00224825    # or    r9, r1, r2
p bfc00028 01255026    # xor   r10, r9, r5
p bfc0002c 24200007    # addiu r0, r1, 7
p bfc00030 10290002    # beq   r1, r9, not taken
p bfc00034 240b0011    # addiu r11, r0, 0x11
p bfc00038 15610002    # bne   r11, r1, taken to 0x44
p bfc0003c 240c0bad    # flushed
p bfc00040 240d0bad    # flushed
p bfc00044 240e0022    # addiu r14, r0, 0x22
p bfc00048 11ce0001    # beq   r14, r14, taken to 0x50
p bfc0004c 240f0bad    # flushed
p bfc00050 01cb8021    # addu  r16, r14, r11
p bfc00054 00108823    # subu  r17, r0, r16
t bfc00000 01 00000005
t bfc00004 02 00000008
t bfc00008 03 0000000d
t bfc0000c 04 00000008
t bfc00010 05 80000000
t bfc00014 05 80001234
t bfc00018 06 00000001
t bfc0001c 07 00000000
t bfc00020 08 00000004
t bfc00024 09 0000000d
t bfc00028 0a 80001239
t bfc00034 0b 00000011
t bfc00044 0e 00000022
t bfc00050 10 00000033
t bfc00054 11 ffffffcd

/* tests/tb_clock_gen.sv */
// ##################################################
// testbench clock and power-on reset
// ##################################################
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen #(
    parameter int PERIOD_NS      = 20,
    parameter int RESET_CYCLES   = 2,
    parameter int DRIVE_DELAY_NS = 2
) (
    output logic aclk,
    output logic reset
);

    initial begin
        aclk = 1'b0;
        forever #(PERIOD_NS / 2) aclk = ~aclk;
    end

    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge aclk);
        #DRIVE_DELAY_NS;
        reset = 1'b0;                               // released just after the edge
    end

endmodule

`default_nettype wire

/* tests/tb_top.sv */
// ##################################################
// cpu core testbench with instruction memory model,
// fetch stall driver, write-back trace checker,
// watchdog and two runs of the program
// ##################################################
`timescale 1ns/1ns
`default_nettype none
`include "cpu_config.svh"

module tb_top;

    localparam int IMEM_WORDS   = 64;
    localparam int RESET_CYCLES = 2;
    localparam int DRIVE_DELAY  = 2;
    localparam int DRAIN_CYCLES = 16;

    logic                       aclk;
    logic                       por_reset;
    logic                       run_reset;
    logic                       reset;
    logic                       instr_ready;
    logic [`CPU_XLEN-1:0]       instr;
    logic [`CPU_XLEN-1:0]       fetch_pc;
    logic [`CPU_XLEN-1:0]       debug_wb_pc;
    logic [`CPU_XLEN-1:0]       debug_wb_rf_wdata;
    logic [3:0]                 debug_wb_rf_wen;
    logic [`CPU_REG_ADDR_W-1:0] debug_wb_rf_wnum;

    logic [`CPU_XLEN-1:0] imem [IMEM_WORDS];
    bit                   imem_loaded [IMEM_WORDS];
    logic [`CPU_XLEN-1:0] exp_pc [$];
    logic [`CPU_XLEN-1:0] exp_num [$];
    logic [`CPU_XLEN-1:0] exp_data [$];
    int                   trace_len;
    int                   trace_idx;
    bit                   checking;
    bit                   random_stalls;
    integer               seed;

    tb_clock_gen #(.PERIOD_NS(20), .RESET_CYCLES(RESET_CYCLES)) u_clock_gen (
        .aclk  (aclk),
        .reset (por_reset)
    );

    assign reset = por_reset || run_reset;          // power-on or rerun

    mycpu_top mycpu_top_i (
        .aclk              (aclk),
        .reset             (reset),
        .instr_ready       (instr_ready),
        .instr             (instr),
        .fetch_pc          (fetch_pc),
        .debug_wb_pc       (debug_wb_pc),
        .debug_wb_rf_wdata (debug_wb_rf_wdata),
        .debug_wb_rf_wen   (debug_wb_rf_wen),
        .debug_wb_rf_wnum  (debug_wb_rf_wnum)
    );

    // unloaded words read as a reserved opcode mixed with the address
    function automatic logic [`CPU_XLEN-1:0] imem_read(input logic [`CPU_XLEN-1:0] addr);
        logic [`CPU_XLEN-1:0] offset;
        int                   idx;
        offset = addr - `CPU_RESET_PC;
        idx    = int'(offset[`CPU_XLEN-1:2]);
        if (idx < IMEM_WORDS && imem_loaded[idx]) begin
            return imem[idx];
        end else begin
            return {6'h3f, addr[25:0] ^ {20'd0, addr[31:26]}};
        end
    endfunction

    always_comb instr = imem_read(fetch_pc);       // combinational instruction port

    task automatic stop_on_error();
        $display("Test failed");
        $fatal(1, "simulation stopped at %0t ns", $time);
    endtask

    task automatic check_value(input string name, input logic [`CPU_XLEN-1:0] actual,
                               input logic [`CPU_XLEN-1:0] expected);
        if (actual !== expected) begin
            $display("CHECK FAILED at %0t ns: %s = %h, expected %h",
                     $time, name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic load_stim();
        int                   fd;
        int                   n;
        int                   idx;
        string                line;
        byte                  first;
        logic [7:0]           tag;
        logic [`CPU_XLEN-1:0] a;
        logic [`CPU_XLEN-1:0] b;
        logic [`CPU_XLEN-1:0] c;
        logic [`CPU_XLEN-1:0] offset;
        fd = $fopen("tests/cpu_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open tests/cpu_stim.txt");
            stop_on_error();
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (n > 0 && line.len() > 2) begin
                first = line[0];
                if (first == "p") begin
                    n      = $sscanf(line, "%c %h %h", tag, a, b);
                    offset = a - `CPU_RESET_PC;
                    idx    = int'(offset[`CPU_XLEN-1:2]);
                    if (n != 3 || idx >= IMEM_WORDS) begin
                        $display("bad program line in stimulus file: %s", line);
                        stop_on_error();
                    end
                    imem[idx]        = b;
                    imem_loaded[idx] = 1'b1;
                end else if (first == "t") begin
                    n = $sscanf(line, "%c %h %h %h", tag, a, b, c);
                    if (n != 4) begin
                        $display("bad trace line in stimulus file: %s", line);
                        stop_on_error();
                    end
                    exp_pc.push_back(a);
                    exp_num.push_back(b);
                    exp_data.push_back(c);
                end else if (first != "#") begin
                    $display("unknown line in stimulus file: %s", line);
                    stop_on_error();
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        trace_len = exp_pc.size();
        if (trace_len == 0) begin
            $display("stimulus file holds no trace entries");
            stop_on_error();
        end
    endtask

    task automatic compare_writeback();
        if (trace_idx >= trace_len) begin
            $display("unexpected write-back of r%0d at pc %h after the trace ended",
                     debug_wb_rf_wnum, debug_wb_pc);
            stop_on_error();
        end else begin
            check_value("debug_wb_pc", debug_wb_pc, exp_pc[trace_idx]);
            check_value("debug_wb_rf_wnum", {27'd0, debug_wb_rf_wnum}, exp_num[trace_idx]);
            check_value("debug_wb_rf_wdata", debug_wb_rf_wdata, exp_data[trace_idx]);
            check_value("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, 32'h0000000f);
            trace_idx++;
        end
    endtask

    task automatic run_program(input bit stalls);
        @(posedge aclk);
        #DRIVE_DELAY;
        run_reset = 1'b1;
        checking  = 1'b0;
        @(posedge aclk);
        @(negedge aclk);
        check_value("fetch_pc", fetch_pc, `CPU_RESET_PC);
        check_value("debug_wb_rf_wen", {28'd0, debug_wb_rf_wen}, '0);
        random_stalls = stalls;
        repeat (RESET_CYCLES - 1) @(posedge aclk);
        #DRIVE_DELAY;
        run_reset = 1'b0;
        trace_idx = 0;
        checking  = 1'b1;
        wait (trace_idx == trace_len);
        repeat (DRAIN_CYCLES) @(posedge aclk);      // catch stray write-backs
        checking = 1'b0;
    endtask

    // trace sampled mid-cycle
    always @(negedge aclk) begin
        if (checking && debug_wb_rf_wen != 4'b0000) begin
            compare_writeback();
        end
    end

    always @(posedge aclk) begin
        #DRIVE_DELAY;
        if (random_stalls) begin
            instr_ready = ($random(seed) & 1) != 0;     // busy about half the time
        end else begin
            instr_ready = 1'b1;
        end
    end

    initial begin : watchdog
        int limit;
        wait (trace_len > 0);
        limit = 8 * trace_len * 3 + 2 * (RESET_CYCLES + 2);
        repeat (limit) @(posedge aclk);
        $display("timeout after %0d cycles, the trace was not finished", limit);
        stop_on_error();
    end

    initial begin
        instr_ready   = 1'b1;
        run_reset     = 1'b0;
        checking      = 1'b0;
        random_stalls = 1'b0;
        trace_idx     = 0;
        seed          = 32'hf5ce9a5a;
        load_stim();
        run_program(1'b0);                          // instr_ready held high
        run_program(1'b1);                          // random fetch stalls
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire
